//--- hw/eth_tx_pkg.sv
// ==========================================================
// Shared constants for the Ethernet transmit byte path
// Stream width is fixed at one byte; fifo_depth must be a power of two
// CRC constants follow the reflected IEEE 802.3 CRC-32
// ==========================================================

package eth_tx_pkg;

	// Stream data width in bits
	localparam int data_width = 8;

	// Minimum frame length before the FCS
	localparam int min_frame_len = 60;

	// Value of each pad byte
	localparam logic [data_width-1:0] pad_byte = 8'h00;

	// Byte FIFO entries, not counting the output register
	localparam int fifo_depth = 16;

	// Number of trailing FCS bytes
	localparam int fcs_len = 4;

	// Reflected CRC-32 polynomial
	localparam logic [31:0] crc_poly = 32'hEDB88320;

	// Seed of the CRC register, also XORed onto the final value
	localparam logic [31:0] crc_init = 32'hFFFFFFFF;

endpackage

//--- hw/axis_if.sv
// ==========================================================
// Byte stream with valid/ready/last handshake
// Source holds tdata, tvalid and tlast while tready is low
// ==========================================================

interface axis_if;

	logic [eth_tx_pkg::data_width-1:0] tdata;
	logic tvalid;
	logic tready;
	// Final beat of a frame
	logic tlast;

	modport source (
		output tdata,
		output tvalid,
		output tlast,
		input tready
	);

	modport sink (
		input tdata,
		input tvalid,
		input tlast,
		output tready
	);

endinterface

//--- hw/axis_fifo.sv
// ==========================================================
// Plain byte FIFO, frames are not held back as whole packets
// Output is a registered head entry, one extra beat of storage
// Depth must be a power of two so the pointers wrap by themselves
// ==========================================================

module axis_fifo (
	input logic clk,
	input logic sresetn,
	axis_if.sink in,
	axis_if.source out
);

	// Each entry is {last, data}
	logic [eth_tx_pkg::data_width:0] mem [eth_tx_pkg::fifo_depth];

	logic [$clog2(eth_tx_pkg::fifo_depth)-1:0] wr_ptr;
	logic [$clog2(eth_tx_pkg::fifo_depth)-1:0] rd_ptr;
	logic [$clog2(eth_tx_pkg::fifo_depth+1)-1:0] count;

	// Output head register
	logic out_valid;
	logic [eth_tx_pkg::data_width:0] out_entry;

	logic full;
	logic empty;
	logic wr;
	logic out_free;
	logic pop;
	logic bypass;
	logic mem_wr;

	assign full = (count == eth_tx_pkg::fifo_depth);
	assign empty = (count == 0);
	assign in.tready = !full;
	assign wr = in.tvalid && in.tready;

	// Head register can take a new entry this cycle
	assign out_free = !out_valid || out.tready;
	assign pop = !empty && out_free;

	// Empty buffer and free head, so the beat skips the RAM
	assign bypass = wr && empty && out_free;
	assign mem_wr = wr && !bypass;

	// Storage array, no reset
	always_ff @(posedge clk) begin
		if (mem_wr) begin
			mem[wr_ptr] <= {in.tlast, in.tdata};
		end
	end

	// Pointers, occupancy and head valid
	always_ff @(posedge clk) begin
		if (!sresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			out_valid <= 1'b0;
		end else begin
			if (mem_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({mem_wr, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// Head refills from the RAM first, else straight from the input
			if (out_free) begin
				out_valid <= !empty || wr;
			end
		end
	end

	// Head payload, held while the sink stalls
	always_ff @(posedge clk) begin
		if (pop) begin
			out_entry <= mem[rd_ptr];
		end else if (bypass) begin
			out_entry <= {in.tlast, in.tdata};
		end
	end

	assign out.tvalid = out_valid;
	assign out.tdata = out_entry[eth_tx_pkg::data_width-1:0];
	assign out.tlast = out_entry[eth_tx_pkg::data_width];

	// Occupancy matches the pointers and never passes the depth
	assert property (@(posedge clk) disable iff (!sresetn)
		count <= eth_tx_pkg::fifo_depth
		&& count[$clog2(eth_tx_pkg::fifo_depth)-1:0] == wr_ptr - rd_ptr);

endmodule

//--- hw/axis_padder.sv
// ==========================================================
// Pads frames shorter than min_frame_len with pad_byte
// Longer frames pass unchanged; zero cycles of latency
// ==========================================================

module axis_padder (
	input logic clk,
	input logic sresetn,
	axis_if.sink in,
	axis_if.source out
);

	// Low in passthrough, high while emitting pad bytes
	logic pad_state;

	// Output beats of the current frame, saturating at the minimum less one
	logic [$clog2(eth_tx_pkg::min_frame_len)-1:0] ctr;
	logic at_min;

	logic out_beat;

	assign at_min = (ctr == eth_tx_pkg::min_frame_len - 1);
	assign out_beat = out.tvalid && out.tready;

	always_ff @(posedge clk) begin
		if (!sresetn) begin
			pad_state <= 1'b0;
			ctr <= '0;
		end else begin
			// Count accepted output beats, clear at frame end
			if (out_beat) begin
				if (out.tlast) begin
					ctr <= '0;
				end else if (!at_min) begin
					ctr <= ctr + 1'b1;
				end
			end
			if (!pad_state) begin
				// Input frame ended short of the minimum
				if (in.tvalid && in.tready && in.tlast && !at_min) begin
					pad_state <= 1'b1;
				end
			end else if (out_beat && out.tlast) begin
				pad_state <= 1'b0;
			end
		end
	end

	always_comb begin
		if (pad_state) begin
			// Input held off while pad bytes go out
			in.tready = 1'b0;
			out.tvalid = 1'b1;
			out.tdata = eth_tx_pkg::pad_byte;
			out.tlast = at_min;
		end else begin
			in.tready = out.tready;
			out.tvalid = in.tvalid;
			out.tdata = in.tdata;
			// Input last only counts once the minimum is reached
			out.tlast = at_min && in.tlast;
		end
	end

	// Pad burst is never withdrawn before its last beat
	assert property (@(posedge clk) disable iff (!sresetn)
		(pad_state && !(out_beat && out.tlast)) |=> pad_state && out.tvalid);

endmodule

//--- hw/axis_fcs_append.sv
// ==========================================================
// Appends the CRC-32 FCS after each frame, LSB byte first
// Data beats pass combinationally with their last flag dropped
// Input is stalled for the four FCS beats
// ==========================================================

module axis_fcs_append (
	input logic clk,
	input logic sresetn,
	axis_if.sink in,
	axis_if.source out
);

	// Running CRC over the frame so far
	logic [31:0] crc;

	// High while the FCS bytes go out
	logic fcs_phase;
	logic [1:0] fcs_idx;

	logic [31:0] fcs_word;
	logic in_beat;
	logic out_beat;
	logic fcs_done;

	// One byte of reflected CRC-32, bit at a time
	function automatic logic [31:0] crc_byte(
		input logic [31:0] crc_in,
		input logic [eth_tx_pkg::data_width-1:0] data
	);
		logic [31:0] c;
		int i;
		c = crc_in ^ {24'd0, data};
		for (i = 0; i < 8; i++) begin
			if (c[0]) begin
				c = (c >> 1) ^ eth_tx_pkg::crc_poly;
			end else begin
				c = c >> 1;
			end
		end
		return c;
	endfunction

	assign in_beat = in.tvalid && in.tready;
	assign out_beat = out.tvalid && out.tready;

	// Final XOR gives the transmitted FCS
	assign fcs_word = crc ^ eth_tx_pkg::crc_init;
	assign fcs_done = (fcs_idx == eth_tx_pkg::fcs_len - 1);

	always_ff @(posedge clk) begin
		if (!sresetn) begin
			crc <= eth_tx_pkg::crc_init;
			fcs_phase <= 1'b0;
			fcs_idx <= '0;
		end else if (!fcs_phase) begin
			if (in_beat) begin
				crc <= crc_byte(crc, in.tdata);
				// Frame end starts the FCS bytes
				if (in.tlast) begin
					fcs_phase <= 1'b1;
					fcs_idx <= '0;
				end
			end
		end else if (out_beat) begin
			fcs_idx <= fcs_idx + 1'b1;
			if (fcs_done) begin
				// Ready for the next frame
				fcs_phase <= 1'b0;
				crc <= eth_tx_pkg::crc_init;
			end
		end
	end

	always_comb begin
		if (fcs_phase) begin
			in.tready = 1'b0;
			out.tvalid = 1'b1;
			// Byte fcs_idx of the FCS, lowest first
			out.tdata = fcs_word[fcs_idx*eth_tx_pkg::data_width +: eth_tx_pkg::data_width];
			out.tlast = fcs_done;
		end else begin
			in.tready = out.tready;
			out.tvalid = in.tvalid;
			out.tdata = in.tdata;
			out.tlast = 1'b0;
		end
	end

	// Frame end on the output only ever comes from the FCS phase
	assert property (@(posedge clk) disable iff (!sresetn)
		$rose(out.tlast) |-> fcs_phase && fcs_done);

endmodule

//--- hw/eth_tx_path.sv
// ==========================================================
// Ethernet MAC transmit byte path: FIFO, padder, FCS appender
// No preamble, SFD or inter-frame gap; output is frame plus FCS
// ==========================================================

module eth_tx_path (
	input logic clk,
	input logic sresetn,
	input logic [eth_tx_pkg::data_width-1:0] in_tdata,
	input logic in_tvalid,
	output logic in_tready,
	input logic in_tlast,
	output logic [eth_tx_pkg::data_width-1:0] out_tdata,
	output logic out_tvalid,
	input logic out_tready,
	output logic out_tlast
);

	axis_if in_s();
	axis_if fifo_out();
	axis_if pad_out();

	// Frame source side
	assign in_s.tdata = in_tdata;
	assign in_s.tvalid = in_tvalid;
	assign in_s.tlast = in_tlast;
	assign in_tready = in_s.tready;

	axis_fifo u_fifo (
		.clk(clk),
		.sresetn(sresetn),
		.in(in_s),
		.out(fifo_out)
	);

	axis_padder u_padder (
		.clk(clk),
		.sresetn(sresetn),
		.in(fifo_out),
		.out(pad_out)
	);

	// Output stream comes straight off the appender
	axis_if fcs_out();

	axis_fcs_append u_fcs (
		.clk(clk),
		.sresetn(sresetn),
		.in(pad_out),
		.out(fcs_out)
	);

	assign out_tdata = fcs_out.tdata;
	assign out_tvalid = fcs_out.tvalid;
	assign out_tlast = fcs_out.tlast;
	assign fcs_out.tready = out_tready;

endmodule

//--- tb/eth_tx_path_tb.sv
// ============================================================
// Random frames from a fixed seed against a padding and CRC-32 model
// Inputs and out_tready change 1 ns after the rising edge
// Outputs and in_tready are sampled at the falling edge
// ============================================================

module eth_tx_path_tb;

	timeunit 1ns;
	timeprecision 1ps;

	// Cycles any single wait may take
	localparam int wait_limit = 4000;
	// Model's own CRC-32 constants
	localparam logic [31:0] model_poly = 32'hEDB88320;
	localparam logic [31:0] model_init = 32'hFFFFFFFF;

	logic clk;
	logic sresetn;
	logic [eth_tx_pkg::data_width-1:0] in_tdata;
	logic in_tvalid;
	logic in_tready;
	logic in_tlast;
	logic [eth_tx_pkg::data_width-1:0] out_tdata;
	logic out_tvalid;
	logic out_tready;
	logic out_tlast;

	integer seed;
	integer ready_seed;
	int errors;
	int frames_out;
	bit random_ready;
	bit saw_full;
	string test_name;

	// Expected output bytes and last flags, oldest first
	logic [7:0] exp_data[$];
	bit exp_last[$];

	eth_tx_path dut (
		.clk(clk),
		.sresetn(sresetn),
		.in_tdata(in_tdata),
		.in_tvalid(in_tvalid),
		.in_tready(in_tready),
		.in_tlast(in_tlast),
		.out_tdata(out_tdata),
		.out_tvalid(out_tvalid),
		.out_tready(out_tready),
		.out_tlast(out_tlast)
	);

	always #10 clk = ~clk;

	// Sink side, about half ready when randomised
	always @(posedge clk) begin
		#1;
		if (random_ready) begin
			out_tready = ($random(ready_seed) % 2) != 0;
		end else begin
			out_tready = 1'b1;
		end
	end

	task automatic compare(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("[FAIL] %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
		end
	endtask

	task automatic finish_run();
		$display("frames out %0d, errors %0d", frames_out, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout during %s: %s", test_name, what);
		errors++;
		finish_run();
	endtask

	// Reflected CRC-32, one data bit per step
	function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic [7:0] b);
		logic [31:0] c;
		c = crc;
		for (int k = 0; k < 8; k++) begin
			if (c[0] ^ b[k]) begin
				c = (c >> 1) ^ model_poly;
			end else begin
				c = c >> 1;
			end
		end
		return c;
	endfunction

	// Output monitor, every accepted beat against the model queue
	always @(negedge clk) begin
		if (sresetn) begin
			if (!in_tready) begin
				saw_full = 1'b1;
			end
			if (out_tvalid && out_tready) begin
				if (exp_data.size() == 0) begin
					errors++;
					$display("Output byte %0h arrived with no frame expected", out_tdata);
				end else begin
					compare("data", exp_data.pop_front(), out_tdata);
					compare("last", exp_last.pop_front(), out_tlast);
				end
				if (out_tlast) begin
					frames_out++;
				end
			end
		end
	end

	// Entered and left 1 ns after a rising edge
	task automatic send_frame(input int len, input bit gaps);
		logic [7:0] payload[$];
		logic [7:0] b;
		logic [31:0] crc;
		int i;
		int t;
		bit taken;
		for (i = 0; i < len; i++) begin
			b = 8'($random(seed));
			payload.push_back(b);
		end
		// Payload, zero pad up to the minimum, FCS low byte first
		crc = model_init;
		for (i = 0; i < len || i < eth_tx_pkg::min_frame_len; i++) begin
			b = (i < len) ? payload[i] : 8'h00;
			exp_data.push_back(b);
			exp_last.push_back(1'b0);
			crc = crc_step(crc, b);
		end
		crc = crc ^ model_init;
		for (i = 0; i < 4; i++) begin
			exp_data.push_back(crc[8*i +: 8]);
			exp_last.push_back(i == 3);
		end
		for (i = 0; i < len; i++) begin
			// Idle cycle on about a quarter of the beats
			if (gaps && ($random(seed) % 4) == 0) begin
				in_tvalid = 1'b0;
				@(posedge clk);
				#1;
			end
			in_tdata = payload[i];
			in_tvalid = 1'b1;
			in_tlast = (i == len - 1);
			t = 0;
			taken = 1'b0;
			while (!taken) begin
				@(negedge clk);
				taken = in_tready;
				@(posedge clk);
				#1;
				t++;
				if (!taken && t > wait_limit) begin
					report_timeout("in_tready stayed low, input beat never accepted");
				end
			end
		end
		in_tvalid = 1'b0;
		in_tlast = 1'b0;
	endtask

	task automatic wait_drain();
		int t;
		t = 0;
		while (exp_data.size() != 0) begin
			@(posedge clk);
			#1;
			t++;
			if (t > wait_limit) begin
				report_timeout("expected output bytes never arrived");
			end
		end
	endtask

	initial begin
		int i;
		int n;
		clk = 1'b0;
		sresetn = 1'b0;
		in_tdata = '0;
		in_tvalid = 1'b0;
		in_tlast = 1'b0;
		out_tready = 1'b1;
		seed = 32'hcd4750ca;
		ready_seed = $random(seed);
		random_ready = 1'b0;
		saw_full = 1'b0;
		errors = 0;
		frames_out = 0;
		test_name = "reset";
		repeat (10) @(posedge clk);
		#1;
		sresetn = 1'b1;
		// Idle path after reset
		for (i = 0; i < 5; i++) begin
			@(negedge clk);
			compare("out_tvalid", 0, out_tvalid);
			compare("in_tready", 1, in_tready);
		end
		@(posedge clk);
		#1;
		test_name = "short";
		for (i = 0; i < 20; i++) begin
			send_frame(1 + {$random(seed)} % 59, 1'b0);
		end
		wait_drain();
		test_name = "long";
		send_frame(eth_tx_pkg::min_frame_len, 1'b0);
		send_frame(eth_tx_pkg::min_frame_len, 1'b1);
		for (i = 0; i < 10; i++) begin
			send_frame(61 + {$random(seed)} % 140, 1'b1);
		end
		wait_drain();
		// Slow sink, the final long burst fills the FIFO
		test_name = "backpressure";
		random_ready = 1'b1;
		saw_full = 1'b0;
		for (i = 0; i < 10; i++) begin
			send_frame(1 + {$random(seed)} % 200, 1'b1);
		end
		send_frame(200, 1'b0);
		wait_drain();
		compare("in_tready fell", 1, saw_full);
		random_ready = 1'b0;
		test_name = "back_to_back";
		n = frames_out;
		for (i = 0; i < 8; i++) begin
			send_frame(1 + {$random(seed)} % 120, 1'b0);
		end
		wait_drain();
		compare("frame count", 8, frames_out - n);
		finish_run();
	end

endmodule

//--- src.f
hw/eth_tx_pkg.sv
hw/axis_if.sv
hw/axis_fifo.sv
hw/axis_padder.sv
hw/axis_fcs_append.sv
hw/eth_tx_path.sv
tb/eth_tx_path_tb.sv

//--- Bender.yml
package:
  name: eth_tx_path

sources:
  - files:
      - hw/eth_tx_pkg.sv
      - hw/axis_if.sv
      - hw/axis_fifo.sv
      - hw/axis_padder.sv
      - hw/axis_fcs_append.sv
      - hw/eth_tx_path.sv
  - target: test
    files:
      - tb/eth_tx_path_tb.sv
